//--- i2s_audio_pkg.sv
// shared widths, types and frame constants for the i2s output path
// fixed at 16-bit stereo samples carried in 32-bit channel slots
// slot_cnt_t covers SLOT_BITS exactly, so the slot counter wraps by itself
// data occupies the first SAMPLE_WIDTH slots of each half-frame

package i2s_audio_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // bits in one channel sample
  localparam int SAMPLE_WIDTH = 16;

  // bit periods per channel half-frame
  localparam int SLOT_BITS = 32;

  // shifter holds left above right
  localparam int FRAME_WIDTH = 2 * SAMPLE_WIDTH;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // one channel sample, msb first on the wire
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  // shifter contents, {left, right}
  typedef logic [FRAME_WIDTH-1:0] frame_word_t;

  // bit period index inside a half-frame
  typedef logic [$clog2(SLOT_BITS)-1:0] slot_cnt_t;

  // req/ack receiver states
  typedef enum logic [1:0] {
    IDLE,
    ACK_HIGH,
    WAIT_FREE
  } intake_state_t;

  // frame constants
  // last slot of a half-frame, lrck flips after it
  localparam slot_cnt_t LAST_SLOT = slot_cnt_t'(SLOT_BITS - 1);
  // slots that shift data, 0 up to DATA_SLOTS-1
  localparam slot_cnt_t DATA_SLOTS = slot_cnt_t'(SAMPLE_WIDTH);

endpackage

//--- i2s_sample_intake.sv
// stereo sample receiver on a four-phase req/ack handshake
// req comes from another clock domain and passes two sync flops
// left/right must be stable before req rises and until ack is seen
// ack is withheld while the holding pair has not yet been reloaded
`timescale 1ns/1ps

module i2s_sample_intake (
  input  logic                   audgen_mclk,
  input  logic                   reset,
  input  logic                   sample_req,
  input  i2s_audio_pkg::sample_t sample_left,
  input  i2s_audio_pkg::sample_t sample_right,
  input  logic                   reload,
  output logic                   sample_ack,
  output i2s_audio_pkg::sample_t hold_left,
  output i2s_audio_pkg::sample_t hold_right
);

  //////////////////////////////////////////////////
  // req synchronizer
  //////////////////////////////////////////////////

  logic req_meta;
  logic req_sync;

  // only crossing in the design, data words ride on req
  always_ff @(posedge audgen_mclk) begin
    if (reset) begin
      req_meta <= 1'b0;
      req_sync <= 1'b0;
    end else begin
      req_meta <= sample_req;
      req_sync <= req_meta;
    end
  end

  //////////////////////////////////////////////////
  // handshake fsm
  //////////////////////////////////////////////////

  i2s_audio_pkg::intake_state_t state_q;
  i2s_audio_pkg::intake_state_t state_d;
  logic pending;
  logic latch_now;

  // take the pair only when holding is free
  // words are settled by the time req_sync is high
  assign latch_now = req_sync && !pending &&
                     (state_q == i2s_audio_pkg::IDLE ||
                      state_q == i2s_audio_pkg::WAIT_FREE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      i2s_audio_pkg::IDLE: begin
        // new request
        if (req_sync) begin
          if (pending) begin
            state_d = i2s_audio_pkg::WAIT_FREE;
          end else begin
            state_d = i2s_audio_pkg::ACK_HIGH;
          end
        end
      end
      i2s_audio_pkg::WAIT_FREE: begin
        // back-pressure until the next reload
        if (!req_sync) begin
          state_d = i2s_audio_pkg::IDLE;
        end else if (!pending) begin
          state_d = i2s_audio_pkg::ACK_HIGH;
        end
      end
      i2s_audio_pkg::ACK_HIGH: begin
        // producer has dropped req
        if (!req_sync) begin
          state_d = i2s_audio_pkg::IDLE;
        end
      end
      default: begin
        state_d = i2s_audio_pkg::IDLE;
      end
    endcase
  end

  // ack straight from a flop, it goes back across domains
  always_ff @(posedge audgen_mclk) begin
    if (reset) begin
      state_q    <= i2s_audio_pkg::IDLE;
      sample_ack <= 1'b0;
    end else begin
      state_q    <= state_d;
      sample_ack <= (state_d == i2s_audio_pkg::ACK_HIGH);
    end
  end

  //////////////////////////////////////////////////
  // holding registers
  //////////////////////////////////////////////////

  // pending set wins over a reload in the same cycle,
  // the serializer then reloads the older pair
  always_ff @(posedge audgen_mclk) begin
    if (reset) begin
      pending    <= 1'b0;
      hold_left  <= '0;
      hold_right <= '0;
    end else begin
      if (latch_now) begin
        pending    <= 1'b1;
        hold_left  <= sample_left;
        hold_right <= sample_right;
      end else if (reload) begin
        // pair moved into the shifter
        pending <= 1'b0;
      end
    end
  end

endmodule

//--- i2s_frame_timer.sv
// bit clock and frame timing for the i2s output
// sclk period is 2**SCLK_DIV_LOG2 mclk cycles, low half then high half
// bit_strobe marks the last mclk cycle before sclk falls
// lrck low is left, high is right; it resets high so the first half is right
`timescale 1ns/1ps

module i2s_frame_timer #(
  parameter int SCLK_DIV_LOG2 = 2
) (
  input  logic audgen_mclk,
  input  logic reset,
  output logic i2s_sclk,
  output logic audio_lrck,
  output logic bit_strobe,
  output logic shift_en,
  output logic reload
);

  //////////////////////////////////////////////////
  // mclk divider
  //////////////////////////////////////////////////

  logic [SCLK_DIV_LOG2-1:0] div_cnt;

  // free running, wraps every bit period
  always_ff @(posedge audgen_mclk) begin
    if (reset) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // top bit is the bit clock
  assign i2s_sclk = div_cnt[SCLK_DIV_LOG2-1];

  // all ones, sclk falls on the next edge
  assign bit_strobe = &div_cnt;

  //////////////////////////////////////////////////
  // slot counter and lrck
  //////////////////////////////////////////////////

  i2s_audio_pkg::slot_cnt_t slot_cnt;
  logic last_slot;

  assign last_slot = (slot_cnt == i2s_audio_pkg::LAST_SLOT);

  // everything here moves with sclk falling,
  // so lrck is steady at every sclk rise
  always_ff @(posedge audgen_mclk) begin
    if (reset) begin
      slot_cnt   <= '0;
      audio_lrck <= 1'b1;
    end else if (bit_strobe) begin
      // wraps 31 -> 0 on its own
      slot_cnt <= slot_cnt + 1'b1;
      if (last_slot) begin
        // next channel
        audio_lrck <= ~audio_lrck;
      end
    end
  end

  //////////////////////////////////////////////////
  // serializer strobes
  //////////////////////////////////////////////////

  // data slots of the current half
  assign shift_en = (slot_cnt < i2s_audio_pkg::DATA_SLOTS);

  // end of a right half, the left half starts next
  assign reload = bit_strobe && last_slot && audio_lrck;

endmodule

//--- i2s_serializer.sv
// 32-bit i2s shifter with a registered dac bit
// left sits above right, msb goes out first
// dac is driven to zero outside the 16 data periods of each half
// a reload without a fresh sample repeats the held pair
`timescale 1ns/1ps

module i2s_serializer (
  input  logic                   audgen_mclk,
  input  logic                   reset,
  input  logic                   bit_strobe,
  input  logic                   shift_en,
  input  logic                   reload,
  input  i2s_audio_pkg::sample_t hold_left,
  input  i2s_audio_pkg::sample_t hold_right,
  output logic                   audio_dac
);

  //////////////////////////////////////////////////
  // shift register
  //////////////////////////////////////////////////

  i2s_audio_pkg::frame_word_t shifter;
  i2s_audio_pkg::frame_word_t load_word;

  // left in the upper half
  assign load_word = {hold_left, hold_right};

  // cleared so the first right half after reset is silent
  always_ff @(posedge audgen_mclk) begin
    if (reset) begin
      shifter   <= '0;
      audio_dac <= 1'b0;
    end else if (bit_strobe) begin
      // bit for the next period, one strobe behind the shifter
      // gives the one-bit delay after lrck
      audio_dac <= shift_en & shifter[i2s_audio_pkg::FRAME_WIDTH-1];
      if (reload) begin
        // new or repeated pair
        shifter <= load_word;
      end else if (shift_en) begin
        // zero fill from the bottom
        shifter <= {shifter[i2s_audio_pkg::FRAME_WIDTH-2:0], 1'b0};
      end
    end
  end

endmodule

//--- i2s_audio_out.sv
// i2s audio output, stereo samples in, sclk/lrck/dac out
// runs on audgen_mclk, synchronous active-high reset
// sample_req may be asynchronous, the data words must be held until ack
// SCLK_DIV_LOG2 of 1 to 3 selects 2, 4 or 8 mclk cycles per bit
`timescale 1ns/1ps

module i2s_audio_out #(
  parameter int SCLK_DIV_LOG2 = 2
) (
  input  logic                   audgen_mclk,
  input  logic                   reset,
  input  logic                   sample_req,
  input  i2s_audio_pkg::sample_t sample_left,
  input  i2s_audio_pkg::sample_t sample_right,
  output logic                   sample_ack,
  output logic                   i2s_sclk,
  output logic                   audio_lrck,
  output logic                   audio_dac
);

  // timer to serializer strobes
  logic bit_strobe;
  logic shift_en;
  logic reload;

  // pending pair, loaded on reload
  i2s_audio_pkg::sample_t hold_left;
  i2s_audio_pkg::sample_t hold_right;

  //////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////

  i2s_sample_intake i_intake (
    .audgen_mclk  (audgen_mclk),
    .reset        (reset),
    .sample_req   (sample_req),
    .sample_left  (sample_left),
    .sample_right (sample_right),
    .reload       (reload),
    .sample_ack   (sample_ack),
    .hold_left    (hold_left),
    .hold_right   (hold_right)
  );

  //////////////////////////////////////////////////
  // bit clock and framing
  //////////////////////////////////////////////////

  i2s_frame_timer #(
    .SCLK_DIV_LOG2 (SCLK_DIV_LOG2)
  ) i_timer (
    .audgen_mclk (audgen_mclk),
    .reset       (reset),
    .i2s_sclk    (i2s_sclk),
    .audio_lrck  (audio_lrck),
    .bit_strobe  (bit_strobe),
    .shift_en    (shift_en),
    .reload      (reload)
  );

  //////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////

  // reload also frees the intake holding pair
  i2s_serializer i_serializer (
    .audgen_mclk (audgen_mclk),
    .reset       (reset),
    .bit_strobe  (bit_strobe),
    .shift_en    (shift_en),
    .reload      (reload),
    .hold_left   (hold_left),
    .hold_right  (hold_right),
    .audio_dac   (audio_dac)
  );

endmodule

//--- i2s_audio_out_asserts.sv
// concurrent checks on the i2s frame timer, bound into each instance
// all properties are off while reset is high
`timescale 1ns/1ps

module i2s_audio_out_asserts #(
  parameter int SCLK_DIV_LOG2 = 2
) (
  input logic audgen_mclk,
  input logic reset,
  input logic bit_strobe,
  input logic audio_lrck,
  input logic reload
);

  // mclk cycles per bit period
  localparam int SCLK_DIV = 2 ** SCLK_DIV_LOG2;

  // one cycle wide, then again after a full bit period
  a_strobe_period: assert property (@(posedge audgen_mclk) disable iff (reset)
    bit_strobe |=> !bit_strobe [*SCLK_DIV-1] ##1 bit_strobe)
    else $error("bit_strobe width or period wrong");

  // lrck only moves on the edge after a strobe
  a_lrck_on_strobe: assert property (@(posedge audgen_mclk) disable iff (reset)
    !$stable(audio_lrck) |-> $past(bit_strobe))
    else $error("audio_lrck changed away from bit_strobe");

  // reload rides on a strobe and opens a left half
  a_reload_with_strobe: assert property (@(posedge audgen_mclk) disable iff (reset)
    reload |-> bit_strobe ##1 $fell(audio_lrck))
    else $error("reload without bit_strobe or away from the left half start");

  // every left half starts with a reload
  a_left_starts_on_reload: assert property (@(posedge audgen_mclk) disable iff (reset)
    $fell(audio_lrck) |-> $past(reload))
    else $error("left half started without a reload");

endmodule

bind i2s_frame_timer i2s_audio_out_asserts #(
  .SCLK_DIV_LOG2 (SCLK_DIV_LOG2)
) i_asserts (
  .audgen_mclk (audgen_mclk),
  .reset       (reset),
  .bit_strobe  (bit_strobe),
  .audio_lrck  (audio_lrck),
  .reload      (reload)
);

//--- tb_i2s_checks.svh
// compare and frame capture tasks, included inside the testbench module
// they use the testbench's signals and error counters directly
// capture_frame expects the default 16-bit sample in a 32-bit slot
`ifndef TB_I2S_CHECKS_SVH
`define TB_I2S_CHECKS_SVH

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

// one channel word
task automatic compare_sample(input string name, input i2s_audio_pkg::sample_t expected,
                              input i2s_audio_pkg::sample_t actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("[ERROR] %s expected %h actual %h", name, expected, actual);
  end
endtask

// single-bit outputs and derived conditions
task automatic compare_bit(input string name, input logic expected, input logic actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("[ERROR] %s expected %b actual %b", name, expected, actual);
  end
endtask

//////////////////////////////////////////////////
// frame capture
//////////////////////////////////////////////////

// sample dac and lrck at each sclk rise, starting at an lrck fall
task automatic capture_frame(input string name, output i2s_audio_pkg::sample_t left,
                             output i2s_audio_pkg::sample_t right, output time start_time);
  int i;
  int period;
  i2s_audio_pkg::sample_t word_l;
  i2s_audio_pkg::sample_t word_r;
  word_l = '0;
  word_r = '0;
  @(negedge audio_lrck);
  start_time = $time;
  for (i = 0; i < 2 * i2s_audio_pkg::SLOT_BITS; i++) begin
    @(posedge i2s_sclk);
    period = i % i2s_audio_pkg::SLOT_BITS;
    // left half low, right half high
    compare_bit({name, " lrck level"}, (i >= i2s_audio_pkg::SLOT_BITS), audio_lrck);
    if (period >= 1 && period <= i2s_audio_pkg::SAMPLE_WIDTH) begin
      // msb in period 1, lsb in period 16
      if (i < i2s_audio_pkg::SLOT_BITS) begin
        word_l[i2s_audio_pkg::SAMPLE_WIDTH - period] = audio_dac;
      end else begin
        word_r[i2s_audio_pkg::SAMPLE_WIDTH - period] = audio_dac;
      end
    end else begin
      // delay bit and tail padding
      compare_bit({name, " pad bit"}, 1'b0, audio_dac);
    end
  end
  left  = word_l;
  right = word_r;
endtask

`endif

//--- tb_i2s_audio_out.sv
// directed testbench for the i2s audio output
// inputs change 2 ns after the rising mclk edge
// the run is bounded by a watchdog sized from the test frame count
`timescale 1ns/1ps

module tb_i2s_audio_out;

  localparam int SCLK_DIV_LOG2 = 2;
  // mclk period in ns
  localparam int MCLK_PERIOD_NS = 40;
  // mclk cycles in one left plus right frame
  localparam int FRAME_CYCLES = 2 * i2s_audio_pkg::SLOT_BITS * (2 ** SCLK_DIV_LOG2);
  // frames spent by all tests together, with slack for alignment
  localparam int TEST_FRAMES = 10;
  localparam int ACK_LIMIT = 2 * FRAME_CYCLES;

  logic audgen_mclk;
  logic reset;
  logic sample_req;
  i2s_audio_pkg::sample_t sample_left;
  i2s_audio_pkg::sample_t sample_right;
  logic sample_ack;
  logic i2s_sclk;
  logic audio_lrck;
  logic audio_dac;

  int error_count;
  int check_count;

  i2s_audio_out #(
    .SCLK_DIV_LOG2 (SCLK_DIV_LOG2)
  ) i_dut (
    .audgen_mclk  (audgen_mclk),
    .reset        (reset),
    .sample_req   (sample_req),
    .sample_left  (sample_left),
    .sample_right (sample_right),
    .sample_ack   (sample_ack),
    .i2s_sclk     (i2s_sclk),
    .audio_lrck   (audio_lrck),
    .audio_dac    (audio_dac)
  );

  `include "tb_i2s_checks.svh"

  // 40 ns mclk
  initial begin
    audgen_mclk = 1'b0;
    forever #(MCLK_PERIOD_NS / 2) audgen_mclk = ~audgen_mclk;
  end

  // hard stop if a wait never ends
  initial begin
    repeat (TEST_FRAMES * FRAME_CYCLES * 2) @(posedge audgen_mclk);
    $display("watchdog expired, a test is stuck waiting on the DUT");
    $display("Testbench failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  task automatic next_drive_point();
    @(posedge audgen_mclk);
    #2;
  endtask

  // four-phase transfer of one pair, returns when ack is low again
  task automatic offer_pair(input string name, input i2s_audio_pkg::sample_t left,
                            input i2s_audio_pkg::sample_t right, output time ack_time,
                            output int ack_cycles);
    int cycles;
    int held;
    // words settle one cycle ahead of req
    next_drive_point();
    sample_left  = left;
    sample_right = right;
    next_drive_point();
    sample_req = 1'b1;
    cycles = 0;
    while (sample_ack !== 1'b1 && cycles < ACK_LIMIT) begin
      next_drive_point();
      cycles++;
    end
    ack_time   = $time;
    ack_cycles = cycles;
    if (sample_ack !== 1'b1) begin
      error_count++;
      $display("%s: sample_ack never rose after sample_req went high", name);
    end
    // ack must hold while req is high
    for (held = 0; held < 3; held++) begin
      next_drive_point();
      compare_bit({name, " ack held"}, 1'b1, sample_ack);
    end
    sample_req = 1'b0;
    cycles = 0;
    while (sample_ack !== 1'b0 && cycles < ACK_LIMIT) begin
      next_drive_point();
      cycles++;
    end
    if (sample_ack !== 1'b0) begin
      error_count++;
      $display("%s: sample_ack stayed high after sample_req dropped", name);
    end
    compare_bit({name, " ack fall latency"}, 1'b1, cycles <= 4);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    compare_bit("reset sample_ack", 1'b0, sample_ack);
    compare_bit("reset audio_dac", 1'b0, audio_dac);
    compare_bit("reset i2s_sclk", 1'b0, i2s_sclk);
    compare_bit("reset audio_lrck", 1'b1, audio_lrck);
  endtask

  task automatic test_clocking();
    int i;
    logic level;
    // two cycles high, two low, from a rise
    @(posedge i2s_sclk);
    for (i = 0; i < 16; i++) begin
      @(negedge audgen_mclk);
      compare_bit("clocking sclk duty", (i % 4) < 2, i2s_sclk);
    end
    // 32 rises per lrck level
    @(audio_lrck);
    level = audio_lrck;
    for (i = 0; i < 64; i++) begin
      @(posedge i2s_sclk);
      compare_bit("clocking lrck half", (i < 32) ? level : ~level, audio_lrck);
    end
  endtask

  task automatic test_handshake();
    time ack_time;
    int ack_cycles;
    offer_pair("handshake", i2s_audio_pkg::sample_t'($urandom),
               i2s_audio_pkg::sample_t'($urandom), ack_time, ack_cycles);
    // nothing pending here, so no back-pressure
    compare_bit("handshake ack latency", 1'b1, ack_cycles <= 4);
  endtask

  task automatic test_serialization();
    i2s_audio_pkg::sample_t exp_l;
    i2s_audio_pkg::sample_t exp_r;
    i2s_audio_pkg::sample_t got_l;
    i2s_audio_pkg::sample_t got_r;
    time ack_time;
    time start_time;
    int ack_cycles;
    exp_l = i2s_audio_pkg::sample_t'($urandom);
    exp_r = i2s_audio_pkg::sample_t'($urandom);
    // start right after a reload, well clear of the next one
    @(negedge audio_lrck);
    offer_pair("serialization", exp_l, exp_r, ack_time, ack_cycles);
    capture_frame("serialization", got_l, got_r, start_time);
    compare_sample("serialization left", exp_l, got_l);
    compare_sample("serialization right", exp_r, got_r);
  endtask

  task automatic test_back_pressure(output i2s_audio_pkg::sample_t last_l,
                                    output i2s_audio_pkg::sample_t last_r);
    i2s_audio_pkg::sample_t a_l;
    i2s_audio_pkg::sample_t a_r;
    i2s_audio_pkg::sample_t b_l;
    i2s_audio_pkg::sample_t b_r;
    i2s_audio_pkg::sample_t got_l;
    i2s_audio_pkg::sample_t got_r;
    time ack_time;
    time first_start;
    time second_start;
    int ack_cycles;
    a_l = i2s_audio_pkg::sample_t'($urandom);
    a_r = i2s_audio_pkg::sample_t'($urandom);
    b_l = i2s_audio_pkg::sample_t'($urandom);
    b_r = i2s_audio_pkg::sample_t'($urandom);
    @(negedge audio_lrck);
    offer_pair("back-pressure first", a_l, a_r, ack_time, ack_cycles);
    fork
      begin
        // holding is full, ack waits for the reload
        offer_pair("back-pressure second", b_l, b_r, ack_time, ack_cycles);
      end
      begin
        capture_frame("back-pressure first", got_l, got_r, first_start);
        compare_sample("back-pressure first left", a_l, got_l);
        compare_sample("back-pressure first right", a_r, got_r);
        capture_frame("back-pressure second", got_l, got_r, second_start);
        compare_sample("back-pressure second left", b_l, got_l);
        compare_sample("back-pressure second right", b_r, got_r);
      end
    join
    compare_bit("back-pressure ack after load", 1'b1, ack_time > first_start);
    // second pair in the very next frame
    compare_bit("back-pressure consecutive frames", 1'b1,
                (second_start - first_start) == FRAME_CYCLES * MCLK_PERIOD_NS);
    last_l = b_l;
    last_r = b_r;
  endtask

  task automatic test_repeat(input i2s_audio_pkg::sample_t exp_l,
                             input i2s_audio_pkg::sample_t exp_r);
    i2s_audio_pkg::sample_t got_l;
    i2s_audio_pkg::sample_t got_r;
    time start_time;
    // no request, the held pair goes out again
    capture_frame("repeat", got_l, got_r, start_time);
    compare_sample("repeat left", exp_l, got_l);
    compare_sample("repeat right", exp_r, got_r);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    i2s_audio_pkg::sample_t last_l;
    i2s_audio_pkg::sample_t last_r;
    void'($urandom(32'h16ca));
    error_count  = 0;
    check_count  = 0;
    reset        = 1'b1;
    sample_req   = 1'b0;
    sample_left  = '0;
    sample_right = '0;
    repeat (3) @(posedge audgen_mclk);
    #2;
    reset = 1'b0;
    test_reset_state();
    test_clocking();
    test_handshake();
    test_serialization();
    test_back_pressure(last_l, last_r);
    test_repeat(last_l, last_r);
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
i2s_audio_pkg.sv
i2s_sample_intake.sv
i2s_frame_timer.sv
i2s_serializer.sv
i2s_audio_out.sv
i2s_audio_out_asserts.sv
tb_i2s_audio_out.sv
